// File: src/axi3_mem_cfg.svh
`ifndef AXI3_MEM_CFG_SVH
`define AXI3_MEM_CFG_SVH

// ==========================================================================
// Build configuration for the memory-to-AXI3 subsystem
// ==========================================================================

// Byte address width on the AXI3 side
`define AXI_ADDR_WID 12

// Bytes per data word
`define DATA_BYTES 4

// Number of words in the on-chip RAM
`define MEM_DEPTH 256

// Constant transaction ID
`define AXI_ID 0

`endif

// File: src/axi3_mem_pkg.sv
package axi3_mem_pkg;

`include "axi3_mem_cfg.svh"

    // ======================================================================
    // Derived widths
    // ======================================================================
    localparam int DATA_WID     = `DATA_BYTES * 8;
    localparam int ADDR_LSB     = $clog2(`DATA_BYTES);
    localparam int MEM_ADDR_WID = `AXI_ADDR_WID - ADDR_LSB;

    // Word-addressed memory side
    typedef logic [MEM_ADDR_WID-1:0]  mem_addr_t;
    typedef logic [DATA_WID-1:0]      mem_data_t;

    // AXI3 fields
    typedef logic [`AXI_ADDR_WID-1:0] axi_addr_t;
    typedef logic [3:0]               axi_id_t;
    typedef logic [3:0]               axi_len_t;
    typedef logic [2:0]               axi_size_t;
    typedef logic [`DATA_BYTES-1:0]   axi_strb_t;

    // Size code for a full-word beat
    localparam axi_size_t AXI_SIZE = axi_size_t'(ADDR_LSB);

    // Response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // ======================================================================
    // State machines
    // ======================================================================
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        SUB_IDLE,
        SUB_WRITE,
        SUB_BRESP,
        SUB_RDATA
    } sub_state_t;

endpackage

// File: src/mem_sp_to_sdp_adapter.sv
`timescale 1ns/1ps

module mem_sp_to_sdp_adapter (
    input  logic                   clk,
    input  logic                   rst_n,
    // Single-port client side
    input  logic                   req,
    input  logic                   wr,
    input  axi3_mem_pkg::mem_addr_t addr,
    input  axi3_mem_pkg::mem_data_t wdata,
    output logic                   rdy,
    output logic                   ack,
    output logic                   error,
    output axi3_mem_pkg::mem_data_t rdata,
    // Write channel
    output logic                   wr_req,
    output axi3_mem_pkg::mem_addr_t wr_addr,
    output axi3_mem_pkg::mem_data_t wr_data,
    input  logic                   wr_rdy,
    input  logic                   wr_ack,
    input  logic                   wr_error,
    // Read channel
    output logic                   rd_req,
    output axi3_mem_pkg::mem_addr_t rd_addr,
    input  logic                   rd_rdy,
    input  logic                   rd_ack,
    input  axi3_mem_pkg::mem_data_t rd_data,
    input  logic                   rd_error
);
    import axi3_mem_pkg::*;

    // Holding register for the accepted request
    logic      wr_q;
    mem_addr_t addr_q;
    mem_data_t wdata_q;
    // Request still waiting for its channel
    logic      issue;

    // Steer to one channel by direction
    assign wr_req  = issue & wr_q;
    assign rd_req  = issue & ~wr_q;
    assign wr_addr = addr_q;
    assign wr_data = wdata_q;
    assign rd_addr = addr_q;

    // Payload capture on acceptance
    always_ff @(posedge clk) begin
        if (req && rdy) begin
            wr_q    <= wr;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy   <= 1'b1;
            issue <= 1'b0;
            ack   <= 1'b0;
            error <= 1'b0;
            rdata <= '0;
        end else begin
            ack <= 1'b0;
            // Accept one request, then block until done
            if (req && rdy) begin
                rdy   <= 1'b0;
                issue <= 1'b1;
            end else if ((wr_req && wr_rdy) || (rd_req && rd_rdy)) begin
                issue <= 1'b0;
            end
            // Merge channel acks, reads carry data
            if (wr_ack || rd_ack) begin
                ack   <= 1'b1;
                error <= wr_ack ? wr_error : rd_error;
                rdata <= rd_ack ? rd_data : '0;
            end
            // Ready again the cycle after ack
            if (ack) begin
                rdy <= 1'b1;
            end
        end
    end

endmodule

// File: src/axi3_from_mem_adapter.sv
`timescale 1ns/1ps

`include "axi3_mem_cfg.svh"

module axi3_from_mem_adapter (
    input  logic                    clk,
    input  logic                    rst_n,
    // Write channel
    input  logic                    wr_req,
    input  axi3_mem_pkg::mem_addr_t wr_addr,
    input  axi3_mem_pkg::mem_data_t wr_data,
    output logic                    wr_rdy,
    output logic                    wr_ack,
    output logic                    wr_error,
    // Read channel
    input  logic                    rd_req,
    input  axi3_mem_pkg::mem_addr_t rd_addr,
    output logic                    rd_rdy,
    output logic                    rd_ack,
    output axi3_mem_pkg::mem_data_t rd_data,
    output logic                    rd_error,
    // AXI3 write address
    output logic                    awvalid,
    input  logic                    awready,
    output axi3_mem_pkg::axi_addr_t awaddr,
    output axi3_mem_pkg::axi_id_t   awid,
    output axi3_mem_pkg::axi_len_t  awlen,
    output axi3_mem_pkg::axi_size_t awsize,
    // AXI3 write data
    output logic                    wvalid,
    input  logic                    wready,
    output axi3_mem_pkg::mem_data_t wdata,
    output axi3_mem_pkg::axi_strb_t wstrb,
    output logic                    wlast,
    // AXI3 write response
    input  logic                    bvalid,
    output logic                    bready,
    input  axi3_mem_pkg::axi_resp_t bresp,
    input  axi3_mem_pkg::axi_id_t   bid,
    // AXI3 read address
    output logic                    arvalid,
    input  logic                    arready,
    output axi3_mem_pkg::axi_addr_t araddr,
    output axi3_mem_pkg::axi_id_t   arid,
    output axi3_mem_pkg::axi_len_t  arlen,
    output axi3_mem_pkg::axi_size_t arsize,
    // AXI3 read data
    input  logic                    rvalid,
    output logic                    rready,
    input  axi3_mem_pkg::mem_data_t rdata,
    input  axi3_mem_pkg::axi_resp_t rresp,
    input  axi3_mem_pkg::axi_id_t   rid,
    input  logic                    rlast
);
    import axi3_mem_pkg::*;

    localparam axi_id_t ID = axi_id_t'(`AXI_ID);

    // ======================================================================
    // Write engine
    // ======================================================================
    wr_state_t wr_state;
    logic      aw_done;
    logic      w_done;
    axi_addr_t wr_axi_addr;
    mem_data_t wr_data_q;
    logic      aw_hs;
    logic      w_hs;

    assign wr_rdy  = (wr_state == WR_IDLE);
    // AW and W raised together, each dropped after its own handshake
    assign awvalid = (wr_state == WR_ADDR_DATA) && !aw_done;
    assign wvalid  = (wr_state == WR_ADDR_DATA) && !w_done;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    // Single full-word beat
    assign awaddr = wr_axi_addr;
    assign awid   = ID;
    assign awlen  = '0;
    assign awsize = AXI_SIZE;
    assign wdata  = wr_data_q;
    assign wstrb  = '1;
    assign wlast  = 1'b1;
    assign bready = 1'b1;

    // Byte address from word address
    always_ff @(posedge clk) begin
        if (wr_req && wr_rdy) begin
            wr_axi_addr <= {wr_addr, {ADDR_LSB{1'b0}}};
            wr_data_q   <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            wr_ack   <= 1'b0;
            wr_error <= 1'b0;
        end else begin
            wr_ack <= 1'b0;
            case (wr_state)
                WR_IDLE: begin
                    if (wr_req) begin
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        wr_state <= WR_ADDR_DATA;
                    end
                end
                WR_ADDR_DATA: begin
                    if (aw_hs) aw_done <= 1'b1;
                    if (w_hs) w_done <= 1'b1;
                    // Either order, both needed
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        wr_ack   <= 1'b1;
                        wr_error <= (bresp != OKAY) || (bid != ID);
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // ======================================================================
    // Read engine
    // ======================================================================
    rd_state_t rd_state;
    axi_addr_t rd_axi_addr;

    assign rd_rdy  = (rd_state == RD_IDLE);
    assign arvalid = (rd_state == RD_ADDR);
    assign araddr  = rd_axi_addr;
    assign arid    = ID;
    assign arlen   = '0;
    assign arsize  = AXI_SIZE;
    assign rready  = 1'b1;

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) begin
            rd_axi_addr <= {rd_addr, {ADDR_LSB{1'b0}}};
        end
        if (rd_state == RD_DATA && rvalid) begin
            rd_data <= rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
            rd_ack   <= 1'b0;
            rd_error <= 1'b0;
        end else begin
            rd_ack <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (rd_req) rd_state <= RD_ADDR;
                end
                RD_ADDR: begin
                    if (arready) rd_state <= RD_DATA;
                end
                RD_DATA: begin
                    // Single beat, so last must come with it
                    if (rvalid) begin
                        rd_ack   <= 1'b1;
                        rd_error <= (rresp != OKAY) || (rid != ID) || !rlast;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

endmodule

// File: src/axi3_ram_subordinate.sv
`timescale 1ns/1ps

`include "axi3_mem_cfg.svh"

module axi3_ram_subordinate (
    input  logic                    clk,
    input  logic                    rst_n,
    // Write address
    input  logic                    awvalid,
    output logic                    awready,
    input  axi3_mem_pkg::axi_addr_t awaddr,
    input  axi3_mem_pkg::axi_id_t   awid,
    input  axi3_mem_pkg::axi_len_t  awlen,
    input  axi3_mem_pkg::axi_size_t awsize,
    // Write data
    input  logic                    wvalid,
    output logic                    wready,
    input  axi3_mem_pkg::mem_data_t wdata,
    input  axi3_mem_pkg::axi_strb_t wstrb,
    input  logic                    wlast,
    // Write response
    output logic                    bvalid,
    input  logic                    bready,
    output axi3_mem_pkg::axi_resp_t bresp,
    output axi3_mem_pkg::axi_id_t   bid,
    // Read address
    input  logic                    arvalid,
    output logic                    arready,
    input  axi3_mem_pkg::axi_addr_t araddr,
    input  axi3_mem_pkg::axi_id_t   arid,
    input  axi3_mem_pkg::axi_len_t  arlen,
    input  axi3_mem_pkg::axi_size_t arsize,
    // Read data
    output logic                    rvalid,
    input  logic                    rready,
    output axi3_mem_pkg::mem_data_t rdata,
    output axi3_mem_pkg::axi_resp_t rresp,
    output axi3_mem_pkg::axi_id_t   rid,
    output logic                    rlast
);
    import axi3_mem_pkg::*;

    localparam int IDX_WID = $clog2(`MEM_DEPTH);

    sub_state_t state;
    mem_data_t  mem [`MEM_DEPTH];
    mem_addr_t  wr_word;
    mem_addr_t  rd_word;
    logic       wr_ok;
    logic       rd_ok;

    // Word index from byte address
    assign wr_word = awaddr[`AXI_ADDR_WID-1:ADDR_LSB];
    assign rd_word = araddr[`AXI_ADDR_WID-1:ADDR_LSB];

    // Range plus single full-word beat, else SLVERR
    assign wr_ok = (wr_word < `MEM_DEPTH) && (awlen == '0) && (awsize == AXI_SIZE) && wlast;
    assign rd_ok = (rd_word < `MEM_DEPTH) && (arlen == '0) && (arsize == AXI_SIZE);

    // Address and data taken together in SUB_WRITE
    assign awready = (state == SUB_WRITE);
    assign wready  = (state == SUB_WRITE);
    assign arready = (state == SUB_IDLE);
    assign bvalid  = (state == SUB_BRESP);
    assign rvalid  = (state == SUB_RDATA);
    assign rlast   = (state == SUB_RDATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SUB_IDLE;
            bresp <= OKAY;
            bid   <= '0;
            rresp <= OKAY;
            rid   <= '0;
            rdata <= '0;
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                SUB_IDLE: begin
                    // Read wins if both arrive at once
                    if (arvalid) begin
                        rdata <= rd_ok ? mem[rd_word[IDX_WID-1:0]] : '0;
                        rresp <= rd_ok ? OKAY : SLVERR;
                        rid   <= arid;
                        state <= SUB_RDATA;
                    end else if (awvalid && wvalid) begin
                        state <= SUB_WRITE;
                    end
                end
                SUB_WRITE: begin
                    // Byte lanes under wstrb, dropped when out of range
                    if (wr_ok) begin
                        for (int b = 0; b < `DATA_BYTES; b++) begin
                            if (wstrb[b]) mem[wr_word[IDX_WID-1:0]][8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                    bresp <= wr_ok ? OKAY : SLVERR;
                    bid   <= awid;
                    state <= SUB_BRESP;
                end
                SUB_BRESP: begin
                    if (bready) state <= SUB_IDLE;
                end
                SUB_RDATA: begin
                    if (rready) state <= SUB_IDLE;
                end
                default: state <= SUB_IDLE;
            endcase
        end
    end

endmodule

// File: src/axi3_mem_subsys.sv
`timescale 1ns/1ps

module axi3_mem_subsys (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  logic                    wr,
    input  axi3_mem_pkg::mem_addr_t addr,
    input  axi3_mem_pkg::mem_data_t wdata,
    output logic                    rdy,
    output logic                    ack,
    output logic                    error,
    output axi3_mem_pkg::mem_data_t rdata
);
    import axi3_mem_pkg::*;

    // ======================================================================
    // Splitter to adapter
    // ======================================================================
    logic      wr_req, wr_rdy, wr_ack, wr_error;
    mem_addr_t wr_addr;
    mem_data_t wr_data;
    logic      rd_req, rd_rdy, rd_ack, rd_error;
    mem_addr_t rd_addr;
    mem_data_t rd_data;

    // ======================================================================
    // Adapter to RAM
    // ======================================================================
    logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic      arvalid, arready, rvalid, rready, rlast;
    axi_addr_t awaddr, araddr;
    axi_id_t   awid, bid, arid, rid;
    axi_len_t  awlen, arlen;
    axi_size_t awsize, arsize;
    mem_data_t axi_wdata, axi_rdata;
    axi_strb_t wstrb;
    axi_resp_t bresp, rresp;

    mem_sp_to_sdp_adapter u_splitter (
        .clk, .rst_n, .req, .wr, .addr, .wdata, .rdy, .ack, .error, .rdata,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wr_ack, .wr_error,
        .rd_req, .rd_addr, .rd_rdy, .rd_ack, .rd_data, .rd_error
    );

    axi3_from_mem_adapter u_adapter (
        .clk, .rst_n,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wr_ack, .wr_error,
        .rd_req, .rd_addr, .rd_rdy, .rd_ack, .rd_data, .rd_error,
        .awvalid, .awready, .awaddr, .awid, .awlen, .awsize,
        .wvalid, .wready, .wdata (axi_wdata), .wstrb, .wlast,
        .bvalid, .bready, .bresp, .bid,
        .arvalid, .arready, .araddr, .arid, .arlen, .arsize,
        .rvalid, .rready, .rdata (axi_rdata), .rresp, .rid, .rlast
    );

    axi3_ram_subordinate u_ram (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .awid, .awlen, .awsize,
        .wvalid, .wready, .wdata (axi_wdata), .wstrb, .wlast,
        .bvalid, .bready, .bresp, .bid,
        .arvalid, .arready, .araddr, .arid, .arlen, .arsize,
        .rvalid, .rready, .rdata (axi_rdata), .rresp, .rid, .rlast
    );

endmodule

// File: sim/axi3_mem_subsys_props.sv
`timescale 1ns/1ps

module axi3_mem_subsys_props (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    awvalid,
    input  logic                    awready,
    input  axi3_mem_pkg::axi_addr_t awaddr,
    input  axi3_mem_pkg::axi_len_t  awlen,
    input  logic                    wvalid,
    input  logic                    wready,
    input  axi3_mem_pkg::mem_data_t wdata,
    input  logic                    wlast,
    input  logic                    arvalid,
    input  logic                    arready,
    input  axi3_mem_pkg::axi_addr_t araddr
);
    import axi3_mem_pkg::*;

    // ======================================================================
    // Valid and payload held until ready
    // ======================================================================
    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed before awready");

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W valid or data changed before wready");

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid or address changed before arready");

    // Single beat only
    aw_single: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> awlen == axi_len_t'(0))
        else $error("awlen is not zero");

    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wlast)
        else $error("wlast low with wvalid");

endmodule

bind axi3_from_mem_adapter axi3_mem_subsys_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wlast   (wlast),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr)
);

// File: sim/axi3_mem_subsys_tb.sv
`timescale 1ns/1ps

`include "axi3_mem_cfg.svh"

module axi3_mem_subsys_tb;
    import axi3_mem_pkg::*;

    localparam int MAX_TESTS  = 128;
    localparam int WAIT_LIMIT = 64;
    localparam int IDX_WID    = $clog2(`MEM_DEPTH);

    logic      clk;
    logic      rst_n;
    logic      req;
    logic      wr;
    mem_addr_t addr;
    mem_data_t wdata;
    logic      rdy;
    logic      ack;
    logic      error;
    mem_data_t rdata;

    // ======================================================================
    // Stimulus table, expected values filled in from the reference model
    // ======================================================================
    string     t_name [MAX_TESTS];
    logic      t_wr [MAX_TESTS];
    logic      t_hold [MAX_TESTS];
    mem_addr_t t_addr [MAX_TESTS];
    mem_data_t t_wdata [MAX_TESTS];
    mem_data_t t_exp_rdata [MAX_TESTS];
    logic      t_exp_error [MAX_TESTS];
    int        n_tests = 0;

    // Reference copy of the RAM contents
    mem_data_t ref_mem [`MEM_DEPTH];

    int seed = 83;
    int pass_count = 0;
    int fail_count = 0;
    int test_errs = 0;
    int ack_count = 0;
    bit aborted = 1'b0;

    axi3_mem_subsys UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdy   (rdy),
        .ack   (ack),
        .error (error),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every ack pulse, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && ack) ack_count++;
    end

    // Append one entry and advance the reference model
    task automatic add_test(input string name, input logic is_wr, input mem_addr_t a,
                            input mem_data_t d, input logic hold);
        logic in_range;
        in_range = (int'(a) < `MEM_DEPTH);
        t_name[n_tests]      = name;
        t_wr[n_tests]        = is_wr;
        t_hold[n_tests]      = hold;
        t_addr[n_tests]      = a;
        t_wdata[n_tests]     = d;
        t_exp_error[n_tests] = !in_range;
        t_exp_rdata[n_tests] = '0;
        // Out of range writes are dropped, reads give zero
        if (in_range && is_wr) ref_mem[a[IDX_WID-1:0]] = d;
        if (in_range && !is_wr) t_exp_rdata[n_tests] = ref_mem[a[IDX_WID-1:0]];
        n_tests++;
    endtask

    task automatic build_table();
        mem_addr_t a;
        mem_data_t d;
        ref_mem = '{default: '0};
        add_test("read_unwritten", 1'b0, 10'd5, '0, 1'b0);
        add_test("write_basic", 1'b1, 10'd10, 32'hdead_beef, 1'b0);
        add_test("read_basic", 1'b0, 10'd10, '0, 1'b0);
        // Small address window so overwrites happen
        for (int i = 0; i < 40; i++) begin
            a = mem_addr_t'($random(seed) & 31);
            d = $random(seed);
            add_test($sformatf("rand_wr_%0d", i), 1'b1, a, d, 1'b0);
            add_test($sformatf("rand_rd_%0d", i), 1'b0, a, '0, 1'b0);
        end
        add_test("oor_write_256", 1'b1, 10'd256, 32'ha5a5_a5a5, 1'b0);
        add_test("oor_read_256", 1'b0, 10'd256, '0, 1'b0);
        add_test("oor_write_1023", 1'b1, 10'd1023, 32'h5a5a_5a5a, 1'b0);
        add_test("oor_read_1023", 1'b0, 10'd1023, '0, 1'b0);
        add_test("keep_word_0", 1'b0, 10'd0, '0, 1'b0);
        add_test("keep_word_10", 1'b0, 10'd10, '0, 1'b0);
        add_test("keep_word_255", 1'b0, 10'd255, '0, 1'b0);
        // req stays high across these
        add_test("b2b_wr_100", 1'b1, 10'd100, 32'h1111_1111, 1'b1);
        add_test("b2b_wr_101", 1'b1, 10'd101, 32'h2222_2222, 1'b1);
        add_test("b2b_rd_100", 1'b0, 10'd100, '0, 1'b1);
        add_test("b2b_rd_101", 1'b0, 10'd101, '0, 1'b1);
        add_test("b2b_wr_100_again", 1'b1, 10'd100, 32'h3333_3333, 1'b1);
        add_test("b2b_rd_100_again", 1'b0, 10'd100, '0, 1'b1);
    endtask

    task automatic check_data(input string name, input mem_data_t expected,
                              input mem_data_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_error(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected error %b, actual %b", name, expected, actual);
            test_errs++;
        end
    endtask

    // ======================================================================
    // Handshake waits, called 1 ns after a rising edge
    // ======================================================================
    task automatic wait_accept(input string name, output bit timed_out);
        int cycles;
        cycles = 0;
        timed_out = 1'b0;
        while (rdy !== 1'b1 && !timed_out) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= WAIT_LIMIT) timed_out = 1'b1;
        end
        if (timed_out) begin
            $display("Test %s: rdy never came back high to take the request", name);
        end else begin
            // The next edge takes the request
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_ack(input string name, output bit timed_out);
        int cycles;
        cycles = 0;
        timed_out = 1'b0;
        while (ack !== 1'b1 && !timed_out) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= WAIT_LIMIT) timed_out = 1'b1;
        end
        if (timed_out) $display("Test %s: no ack arrived for the request", name);
    endtask

    task automatic run_test(input int i);
        bit timed_out;
        test_errs = 0;
        wr    = t_wr[i];
        addr  = t_addr[i];
        wdata = t_wdata[i];
        req   = 1'b1;
        wait_accept(t_name[i], timed_out);
        if (!timed_out) begin
            if (!t_hold[i]) req = 1'b0;
            // One request in flight, so rdy drops at once
            if (rdy !== 1'b0) begin
                $display("Test %s: rdy stayed high after the request was taken", t_name[i]);
                test_errs++;
            end
            wait_ack(t_name[i], timed_out);
        end
        if (timed_out) begin
            aborted = 1'b1;
            test_errs++;
        end else begin
            check_data(t_name[i], t_exp_rdata[i], rdata);
            check_error(t_name[i], t_exp_error[i], error);
        end
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS  %s", t_name[i]);
        end else begin
            fail_count++;
            $display("FAIL  %s", t_name[i]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle state straight out of reset
        if (rdy !== 1'b1 || ack !== 1'b0) begin
            fail_count++;
            $display("FAIL  reset_state: rdy not high or ack not low after reset");
        end else begin
            pass_count++;
            $display("PASS  reset_state");
        end
        for (int i = 0; i < n_tests && !aborted; i++) begin
            run_test(i);
        end
        req = 1'b0;
        repeat (4) @(posedge clk);
        // Exactly one ack per request
        if (!aborted && ack_count != n_tests) begin
            $display("Mismatch in ack_count: expected %0d, actual %0d", n_tests, ack_count);
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/axi3_mem_pkg.sv
src/mem_sp_to_sdp_adapter.sv
src/axi3_from_mem_adapter.sv
src/axi3_ram_subordinate.sv
src/axi3_mem_subsys.sv
sim/axi3_mem_subsys_props.sv
sim/axi3_mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module axi3_mem_subsys_tb -Mdir obj_dir -o axi3_mem_subsys_sim -f build.f

./obj_dir/axi3_mem_subsys_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
